// ==== source/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Issue queue entries, also the upstream credits at reset
`define EXEC_QUEUE_DEPTH 4

// Most output credits downstream may hand out unspent
`define EXEC_CREDIT_MAX 8

`endif

// ==== source/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		ADDIU   = 6'h09,
		SLTI    = 6'h0a,
		SLTIU   = 6'h0b,
		ANDI    = 6'h0c,
		ORI     = 6'h0d,
		XORI    = 6'h0e,
		LUI     = 6'h0f,
		LB      = 6'h20,
		LH      = 6'h21,
		LWL     = 6'h22,
		LW      = 6'h23,
		LBU     = 6'h24,
		LHU     = 6'h25,
		LWR     = 6'h26,
		SB      = 6'h28,
		SH      = 6'h29,
		SW      = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		SLL   = 6'h00,
		SRL   = 6'h02,
		SRA   = 6'h03,
		SLLV  = 6'h04,
		SRLV  = 6'h06,
		SRAV  = 6'h07,
		MFHI  = 6'h10,
		MTHI  = 6'h11,
		MFLO  = 6'h12,
		MTLO  = 6'h13,
		MULT  = 6'h18,
		MULTU = 6'h19,
		DIV   = 6'h1a,
		DIVU  = 6'h1b,
		ADDU  = 6'h21,
		SUBU  = 6'h23,
		AND   = 6'h24,
		OR    = 6'h25,
		XOR   = 6'h26,
		SLT   = 6'h2a,
		SLTU  = 6'h2b
	} functT; // SPECIAL function field

endpackage

`default_nettype wire

// ==== source/execPkg.sv ====
`default_nettype none

package execPkg;

	typedef enum logic [2:0] {
		HILO_NONE,
		HILO_MULT,
		HILO_MULTU,
		HILO_DIV,
		HILO_DIVU,
		HILO_MTHI,
		HILO_MTLO
	} hiLoOpT;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LBU,
		MEM_LH,
		MEM_LHU,
		MEM_LW,
		MEM_LWL,
		MEM_LWR,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} memOpT;

	typedef enum logic {
		DISPATCH_IDLE,
		DISPATCH_MEM // Waiting on the load/store unit
	} dispatchStateT;

endpackage

`default_nettype wire

// ==== source/issueQueue.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module issueQueue (
	input logic clk,
	input logic rst,
	input logic push,
	input logic [31:0] pushInstruction,
	input logic [31:0] pushData1,
	input logic [31:0] pushData2,
	input logic pop,
	output logic empty,
	output logic [31:0] headInstruction,
	output logic [31:0] headData1,
	output logic [31:0] headData2,
	output logic creditReturn
);
	localparam int Depth = `EXEC_QUEUE_DEPTH;
	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	logic [31:0] instrMem [Depth];
	logic [31:0] data1Mem [Depth];
	logic [31:0] data2Mem [Depth];
	logic [PtrWidth-1:0] readPtr;
	logic [PtrWidth-1:0] writePtr;
	logic [CountWidth-1:0] count;
	logic full;
	logic doPush;
	logic doPop;

	function automatic logic [PtrWidth-1:0] advance(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + PtrWidth'(1);
	endfunction

	assign full = (count == CountWidth'(Depth));
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign headInstruction = instrMem[readPtr];
	assign headData1 = data1Mem[readPtr];
	assign headData2 = data2Mem[readPtr];

	always_ff @(posedge clk) begin
		if (rst) begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (doPush)
				writePtr <= advance(writePtr);
			if (doPop)
				readPtr <= advance(readPtr);
			count <= count + CountWidth'(doPush) - CountWidth'(doPop);
			creditReturn <= doPop; // One credit back per entry freed
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) begin
			instrMem[writePtr] <= pushInstruction;
			data1Mem[writePtr] <= pushData1;
			data2Mem[writePtr] <= pushData2;
		end
	end

endmodule

`default_nettype wire

// ==== source/mipsAlu.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsAlu (
	input logic [31:0] instruction,
	input logic [31:0] readData1,
	input logic [31:0] readData2,
	input logic [31:0] hi,
	input logic [31:0] lo,
	output logic [31:0] aluResult,
	output logic [1:0] byteOffset,
	output logic [3:0] byteEnable,
	output execPkg::hiLoOpT hiLoOp,
	output execPkg::memOpT memOp,
	output logic usesHiLo,
	output logic writesReg
);
	import mipsIsaPkg::*;
	import execPkg::*;

	opcodeT opcode;
	functT funct;
	logic [4:0] shamt;
	logic [31:0] immSE;
	logic [31:0] immZE;
	logic [31:0] effAddr;

	assign opcode = opcodeT'(instruction[31:26]);
	assign funct = functT'(instruction[5:0]);
	assign shamt = instruction[10:6];
	assign immSE = {{16{instruction[15]}}, instruction[15:0]};
	assign immZE = {16'b0, instruction[15:0]};
	assign effAddr = readData1 + immSE;
	assign byteOffset = effAddr[1:0];

	always_comb begin
		aluResult = '0;
		hiLoOp = HILO_NONE;
		memOp = MEM_NONE;
		usesHiLo = 1'b0;
		writesReg = 1'b1;
		case (opcode)
			SPECIAL: begin
				case (funct)
					SLL: aluResult = readData2 << shamt;
					SRL: aluResult = readData2 >> shamt;
					SRA: aluResult = $signed(readData2) >>> shamt;
					SLLV: aluResult = readData2 << readData1[4:0];
					SRLV: aluResult = readData2 >> readData1[4:0];
					SRAV: aluResult = $signed(readData2) >>> readData1[4:0];
					ADDU: aluResult = readData1 + readData2;
					SUBU: aluResult = readData1 - readData2;
					AND: aluResult = readData1 & readData2;
					OR: aluResult = readData1 | readData2;
					XOR: aluResult = readData1 ^ readData2;
					SLT: aluResult = {31'b0, $signed(readData1) < $signed(readData2)};
					SLTU: aluResult = {31'b0, readData1 < readData2};
					MFHI: aluResult = hi;
					MFLO: aluResult = lo;
					MTHI: hiLoOp = HILO_MTHI;
					MTLO: hiLoOp = HILO_MTLO;
					MULT: hiLoOp = HILO_MULT;
					MULTU: hiLoOp = HILO_MULTU;
					DIV: hiLoOp = HILO_DIV;
					DIVU: hiLoOp = HILO_DIVU;
					default: writesReg = 1'b0;
				endcase
				if (funct == MFHI || funct == MFLO || hiLoOp != HILO_NONE)
					usesHiLo = 1'b1; // Must wait out a running divide
				if (hiLoOp != HILO_NONE)
					writesReg = 1'b0;
			end
			ADDIU: aluResult = readData1 + immSE;
			SLTI: aluResult = {31'b0, $signed(readData1) < $signed(immSE)};
			SLTIU: aluResult = {31'b0, readData1 < immSE};
			ANDI: aluResult = readData1 & immZE;
			ORI: aluResult = readData1 | immZE;
			XORI: aluResult = readData1 ^ immZE;
			LUI: aluResult = {instruction[15:0], 16'b0};
			LB: memOp = MEM_LB;
			LBU: memOp = MEM_LBU;
			LH: memOp = MEM_LH;
			LHU: memOp = MEM_LHU;
			LW: memOp = MEM_LW;
			LWL: memOp = MEM_LWL;
			LWR: memOp = MEM_LWR;
			SB: memOp = MEM_SB;
			SH: memOp = MEM_SH;
			SW: memOp = MEM_SW;
			default: writesReg = 1'b0;
		endcase
		if (memOp != MEM_NONE)
			aluResult = {effAddr[31:2], 2'b00}; // Word address for the bus
		if (memOp == MEM_SB || memOp == MEM_SH || memOp == MEM_SW)
			writesReg = 1'b0;
	end

	always_comb begin
		case (memOp)
			MEM_LB, MEM_LBU, MEM_SB: byteEnable = 4'b0001 << byteOffset;
			MEM_LH, MEM_LHU, MEM_SH: byteEnable = byteOffset[1] ? 4'b1100 : 4'b0011;
			MEM_LW, MEM_SW: byteEnable = 4'b1111;
			MEM_LWL: byteEnable = 4'b1111 << byteOffset; // Lanes offset..3
			MEM_LWR: byteEnable = 4'b1111 >> (2'd3 - byteOffset); // Lanes 0..offset
			default: byteEnable = 4'b0000;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/hiLoUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hiLoUnit (
	input logic clk,
	input logic rst,
	input logic start,
	input execPkg::hiLoOpT op,
	input logic [31:0] opA,
	input logic [31:0] opB,
	output logic busy,
	output logic [31:0] hi,
	output logic [31:0] lo
);
	import execPkg::*;

	logic [63:0] productSigned;
	logic [63:0] productUnsigned;
	logic signedDiv;
	logic [31:0] magA;
	logic [31:0] magB;
	logic [31:0] remReg;
	logic [31:0] quotReg;
	logic [31:0] divisorReg;
	logic quotNeg;
	logic remNeg;
	logic divByZero;
	logic [4:0] stepCount;
	logic [32:0] trial;
	logic trialFits;
	logic [31:0] nextRem;
	logic [31:0] nextQuot;

	assign productSigned = {{32{opA[31]}}, opA} * {{32{opB[31]}}, opB};
	assign productUnsigned = {32'b0, opA} * {32'b0, opB};

	assign signedDiv = (op == HILO_DIV);
	assign magA = (signedDiv && opA[31]) ? -opA : opA;
	assign magB = (signedDiv && opB[31]) ? -opB : opB;

	// One restoring step
	assign trial = {remReg, quotReg[31]};
	assign trialFits = (trial >= {1'b0, divisorReg});
	assign nextRem = trialFits ? 32'(trial - {1'b0, divisorReg}) : trial[31:0];
	assign nextQuot = {quotReg[30:0], trialFits};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			stepCount <= '0;
			hi <= '0;
			lo <= '0;
		end else if (busy) begin
			remReg <= nextRem;
			quotReg <= nextQuot;
			stepCount <= stepCount + 5'd1;
			if (stepCount == 5'd31) begin
				busy <= 1'b0;
				hi <= remNeg ? -nextRem : nextRem; // Sign of the dividend
				if (divByZero)
					lo <= '1;
				else
					lo <= quotNeg ? -nextQuot : nextQuot;
			end
		end else if (start) begin
			case (op)
				HILO_MULT: {hi, lo} <= productSigned;
				HILO_MULTU: {hi, lo} <= productUnsigned;
				HILO_DIV, HILO_DIVU: begin
					busy <= 1'b1;
					stepCount <= '0;
					remReg <= '0;
					quotReg <= magA;
					divisorReg <= magB;
					quotNeg <= signedDiv && (opA[31] ^ opB[31]);
					remNeg <= signedDiv && opA[31];
					divByZero <= (opB == '0);
				end
				HILO_MTHI: hi <= opA;
				HILO_MTLO: lo <= opA;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/loadStoreUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
	input logic clk,
	input logic rst,
	input logic start,
	input execPkg::memOpT memOp,
	input logic [31:0] address,
	input logic [1:0] byteOffset,
	input logic [3:0] byteEnable,
	input logic [31:0] rtValue,
	output logic done,
	output logic [31:0] loadResult,
	output logic [31:0] memAddress,
	output logic [3:0] memByteEnable,
	output logic memRead,
	output logic memWrite,
	output logic [31:0] memWriteData,
	input logic memWaitRequest,
	input logic [31:0] memReadData
);
	import execPkg::*;

	memOpT opReg;
	logic [1:0] offsetReg;
	logic [31:0] rtReg;
	logic isStore;
	logic [31:0] storeData;
	logic [7:0] laneByte;
	logic [15:0] laneHalf;
	logic [31:0] laneMask;

	assign isStore = (memOp == MEM_SB || memOp == MEM_SH || memOp == MEM_SW);

	always_comb begin
		case (memOp)
			MEM_SB: storeData = rtValue << {byteOffset, 3'b000};
			MEM_SH: storeData = byteOffset[1] ? {rtValue[15:0], 16'b0} : {16'b0, rtValue[15:0]};
			default: storeData = rtValue;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else if (done) begin
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else if (start && memOp != MEM_NONE) begin
			memRead <= !isStore;
			memWrite <= isStore;
		end
	end

	// Request held steady until the bus accepts it
	always_ff @(posedge clk) begin
		if (start) begin
			memAddress <= address;
			memByteEnable <= byteEnable;
			memWriteData <= storeData;
			opReg <= memOp;
			offsetReg <= byteOffset;
			rtReg <= rtValue;
		end
	end

	assign done = (memRead || memWrite) && !memWaitRequest;

	assign laneByte = memReadData[{offsetReg, 3'b000} +: 8];
	assign laneHalf = offsetReg[1] ? memReadData[31:16] : memReadData[15:0];
	assign laneMask = {{8{memByteEnable[3]}}, {8{memByteEnable[2]}},
		{8{memByteEnable[1]}}, {8{memByteEnable[0]}}};

	always_comb begin
		case (opReg)
			MEM_LB: loadResult = {{24{laneByte[7]}}, laneByte};
			MEM_LBU: loadResult = {24'b0, laneByte};
			MEM_LH: loadResult = {{16{laneHalf[15]}}, laneHalf};
			MEM_LHU: loadResult = {16'b0, laneHalf};
			MEM_LW: loadResult = memReadData;
			MEM_LWL, MEM_LWR: loadResult = (memReadData & laneMask) | (rtReg & ~laneMask); // Merge with rt
			default: loadResult = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/mipsExecCore.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module mipsExecCore (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [31:0] instruction,
	input logic [31:0] readData1,
	input logic [31:0] readData2,
	output logic instrCredit,
	output logic resultValid,
	output logic [31:0] result,
	output logic resultWrite,
	input logic resultCredit,
	output logic [31:0] memAddress,
	output logic [3:0] memByteEnable,
	output logic memRead,
	output logic memWrite,
	output logic [31:0] memWriteData,
	input logic memWaitRequest,
	input logic [31:0] memReadData
);
	import execPkg::*;

	localparam int CreditWidth = $clog2(`EXEC_CREDIT_MAX + 1);

	dispatchStateT state;
	logic [CreditWidth-1:0] creditCount;
	logic queueEmpty;
	logic [31:0] headInstruction;
	logic [31:0] headData1;
	logic [31:0] headData2;
	logic [31:0] aluResult;
	logic [1:0] byteOffset;
	logic [3:0] byteEnable;
	hiLoOpT hiLoOp;
	memOpT memOp;
	logic usesHiLo;
	logic writesReg;
	logic hiLoBusy;
	logic [31:0] hi;
	logic [31:0] lo;
	logic lsuDone;
	logic [31:0] loadResult;
	logic dispatch;
	logic isMemOp;
	logic lsuStart;
	logic memBeat;
	logic memWritesReg;

	issueQueue u_queue (
		.clk(clk), .rst(rst),
		.push(instrValid), .pushInstruction(instruction),
		.pushData1(readData1), .pushData2(readData2),
		.pop(dispatch), .empty(queueEmpty),
		.headInstruction(headInstruction), .headData1(headData1), .headData2(headData2),
		.creditReturn(instrCredit)
	);

	mipsAlu u_alu (
		.instruction(headInstruction), .readData1(headData1), .readData2(headData2),
		.hi(hi), .lo(lo), .aluResult(aluResult), .byteOffset(byteOffset),
		.byteEnable(byteEnable), .hiLoOp(hiLoOp), .memOp(memOp),
		.usesHiLo(usesHiLo), .writesReg(writesReg)
	);

	hiLoUnit u_hiLo (
		.clk(clk), .rst(rst), .start(dispatch), .op(hiLoOp),
		.opA(headData1), .opB(headData2), .busy(hiLoBusy), .hi(hi), .lo(lo)
	);

	loadStoreUnit u_lsu (
		.clk(clk), .rst(rst), .start(lsuStart), .memOp(memOp), .address(aluResult),
		.byteOffset(byteOffset), .byteEnable(byteEnable), .rtValue(headData2),
		.done(lsuDone), .loadResult(loadResult),
		.memAddress(memAddress), .memByteEnable(memByteEnable), .memRead(memRead),
		.memWrite(memWrite), .memWriteData(memWriteData),
		.memWaitRequest(memWaitRequest), .memReadData(memReadData)
	);

	// A beat waiting in the result register still holds its credit
	assign dispatch = !queueEmpty && state == DISPATCH_IDLE
		&& creditCount > CreditWidth'(resultValid) && !(usesHiLo && hiLoBusy);
	assign isMemOp = (memOp != MEM_NONE);
	assign lsuStart = dispatch && isMemOp;
	assign memBeat = (state == DISPATCH_MEM) && lsuDone;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DISPATCH_IDLE;
			creditCount <= '0;
			resultValid <= 1'b0;
		end else begin
			creditCount <= creditCount + CreditWidth'(resultCredit) - CreditWidth'(resultValid);
			resultValid <= (dispatch && !isMemOp) || memBeat;
			case (state)
				DISPATCH_IDLE: if (lsuStart) state <= DISPATCH_MEM;
				DISPATCH_MEM: if (lsuDone) state <= DISPATCH_IDLE;
				default: state <= DISPATCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lsuStart)
			memWritesReg <= writesReg; // Loads write, stores do not
		if (dispatch && !isMemOp) begin
			result <= aluResult;
			resultWrite <= writesReg;
		end else if (memBeat) begin
			result <= loadResult;
			resultWrite <= memWritesReg;
		end
	end

endmodule

`default_nettype wire

// ==== verif/mipsExec_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module mipsExec_checker #(
	parameter int CreditWidth = $clog2(`EXEC_CREDIT_MAX + 1)
) (
	input logic clk,
	input logic rst,
	input logic memRead,
	input logic memWrite,
	input logic memWaitRequest,
	input logic [31:0] memAddress,
	input logic [3:0] memByteEnable,
	input logic [31:0] memWriteData,
	input logic resultValid,
	input logic [CreditWidth-1:0] creditCount
);

	// One bus access per memory instruction
	accessEndsOnCompletion: assert property (@(posedge clk) disable iff (rst)
		(memRead || memWrite) && !memWaitRequest
		|=> !(memRead || memWrite))
		else $error("Memory request still asserted after the bus accepted it");

	busStableUnderWait: assert property (@(posedge clk) disable iff (rst)
		(memRead || memWrite) && memWaitRequest
		|=> $stable({memRead, memWrite, memAddress, memByteEnable, memWriteData}))
		else $error("Memory request changed while memWaitRequest was high");

	beatNeedsCredit: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> creditCount != '0)
		else $error("Result beat issued with no output credit held");

	creditBound: assert property (@(posedge clk) disable iff (rst)
		creditCount <= CreditWidth'(`EXEC_CREDIT_MAX))
		else $error("Output credit count above its maximum");

endmodule

bind mipsExecCore mipsExec_checker u_checker (
	.clk(clk), .rst(rst), .memRead(memRead), .memWrite(memWrite),
	.memWaitRequest(memWaitRequest), .memAddress(memAddress),
	.memByteEnable(memByteEnable), .memWriteData(memWriteData),
	.resultValid(resultValid), .creditCount(creditCount)
);

`default_nettype wire

// ==== verif/mipsExecTb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_config.svh"

module mipsExecTb;
	import mipsIsaPkg::*;

	localparam int NumInstr = 300;
	localparam logic [5:0] FunctList [21] = '{SLL, SRL, SRA, SLLV, SRLV, SRAV, MFHI, MTHI,
		MFLO, MTLO, MULT, MULTU, DIV, DIVU, ADDU, SUBU, AND, OR, XOR, SLT, SLTU};
	localparam logic [5:0] OpList [17] = '{ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LB, LH, LWL, LW, LBU, LHU, LWR, SB, SH, SW};

	logic clk;
	logic rst;
	logic instrValid;
	logic [31:0] instruction;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic instrCredit;
	logic resultValid;
	logic [31:0] result;
	logic resultWrite;
	logic resultCredit;
	logic [31:0] memAddress;
	logic [3:0] memByteEnable;
	logic memRead;
	logic memWrite;
	logic [31:0] memWriteData;
	logic memWaitRequest;
	logic [31:0] memReadData;

	logic [15:0] lfsrState;
	logic [31:0] busMem [64]; // Memory seen by the DUT
	logic [31:0] modelMem [64];
	logic [31:0] modelHi;
	logic [31:0] modelLo;
	logic [31:0] expValue [$];
	logic expWrite [$];
	string expName [$];
	int sentCount, beatCount, upCredits, downCredits, creditPulses, drainCycles;
	int valueErrors, protocolErrors, memoryErrors;

	mipsExecCore u_dut (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instruction(instruction),
		.readData1(readData1), .readData2(readData2), .instrCredit(instrCredit),
		.resultValid(resultValid), .result(result), .resultWrite(resultWrite),
		.resultCredit(resultCredit), .memAddress(memAddress), .memByteEnable(memByteEnable),
		.memRead(memRead), .memWrite(memWrite), .memWriteData(memWriteData),
		.memWaitRequest(memWaitRequest), .memReadData(memReadData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		logic feedback;
		value = 32'h0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] pickOperand();
		if (randBits(2) != 0)
			return randBits(32);
		case (2'(randBits(2))) // Corner values
			2'd0: return 32'h00000000;
			2'd1: return 32'hffffffff;
			2'd2: return 32'h80000000;
			default: return 32'h7fffffff;
		endcase
	endfunction

	task automatic modelExecute(input logic [31:0] instr, input logic [31:0] rs,
		input logic [31:0] rt);
		logic [31:0] immS, immZ, ea, word, value, magA, magB, quot, rem;
		logic [7:0] byteVal;
		logic [15:0] halfVal;
		logic [5:0] idx;
		logic [1:0] k;
		logic sgn;
		logic write;
		string name;
		immS = {{16{instr[15]}}, instr[15:0]};
		immZ = {16'h0, instr[15:0]};
		ea = rs + immS;
		idx = ea[7:2];
		k = ea[1:0];
		word = modelMem[idx];
		byteVal = word[k*8 +: 8];
		halfVal = k[1] ? word[31:16] : word[15:0];
		sgn = (instr[5:0] == DIV);
		magA = (sgn && rs[31]) ? -rs : rs;
		magB = (sgn && rt[31]) ? -rt : rt;
		value = 32'h0;
		write = 1'b1;
		name = (instr[31:29] == 3'b100) ? "LOAD" : (instr[31:29] == 3'b101) ? "STORE" : "ALU";
		if (instr[31:26] == SPECIAL) begin
			case (instr[5:0])
				SLL: value = rt << instr[10:6];
				SRL: value = rt >> instr[10:6];
				SRA: value = $signed(rt) >>> instr[10:6];
				SLLV: value = rt << rs[4:0];
				SRLV: value = rt >> rs[4:0];
				SRAV: value = $signed(rt) >>> rs[4:0];
				ADDU: value = rs + rt;
				SUBU: value = rs - rt;
				AND: value = rs & rt;
				OR: value = rs | rt;
				XOR: value = rs ^ rt;
				SLT: value = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
				SLTU: value = (rs < rt) ? 32'd1 : 32'd0;
				MFHI: value = modelHi;
				MFLO: value = modelLo;
				MTHI: modelHi = rs;
				MTLO: modelLo = rs;
				MULT: {modelHi, modelLo} = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};
				MULTU: {modelHi, modelLo} = {32'h0, rs} * {32'h0, rt};
				DIV, DIVU: begin
					if (rt == 32'h0) begin
						modelHi = rs;
						modelLo = 32'hffffffff;
					end else begin
						quot = magA / magB;
						rem = magA % magB;
						modelLo = (sgn && (rs[31] != rt[31])) ? -quot : quot;
						modelHi = (sgn && rs[31]) ? -rem : rem; // Sign of the dividend
					end
				end
				default: ;
			endcase
			if (instr[5:4] == 2'b01)
				name = "HILO";
			write = !(instr[5:0] inside {MTHI, MTLO, MULT, MULTU, DIV, DIVU});
		end else begin
			case (instr[31:26])
				ADDIU: value = rs + immS;
				SLTI: value = ($signed(rs) < $signed(immS)) ? 32'd1 : 32'd0;
				SLTIU: value = (rs < immS) ? 32'd1 : 32'd0;
				ANDI: value = rs & immZ;
				ORI: value = rs | immZ;
				XORI: value = rs ^ immZ;
				LUI: value = {instr[15:0], 16'h0};
				LB: value = {{24{byteVal[7]}}, byteVal};
				LBU: value = {24'h0, byteVal};
				LH: value = {{16{halfVal[15]}}, halfVal};
				LHU: value = {16'h0, halfVal};
				LW: value = word;
				LWL, LWR: begin
					for (int b = 0; b < 4; b++) begin
						if ((instr[31:26] == LWL) ? (b >= k) : (b <= k))
							value[b*8 +: 8] = word[b*8 +: 8];
						else
							value[b*8 +: 8] = rt[b*8 +: 8]; // Lane kept from rt
					end
				end
				SB: modelMem[idx][k*8 +: 8] = rt[7:0];
				SH: begin
					if (k[1])
						modelMem[idx][31:16] = rt[15:0];
					else
						modelMem[idx][15:0] = rt[15:0];
				end
				SW: modelMem[idx] = rt;
				default: ;
			endcase
			if (name == "STORE")
				write = 1'b0;
		end
		expValue.push_back(value);
		expWrite.push_back(write);
		expName.push_back(name);
	endtask

	task automatic sendInstruction();
		logic [4:0] pick;
		logic [19:0] fields;
		logic [15:0] imm;
		logic [5:0] op;
		fields = 20'(randBits(20));
		readData1 = pickOperand();
		readData2 = pickOperand();
		if (randBits(1) != 0) begin
			pick = 5'(randBits(5) % 21);
			instruction = {6'h00, fields, FunctList[pick]};
		end else begin
			pick = 5'(randBits(5) % 17);
			op = OpList[pick];
			imm = 16'(randBits(16));
			instruction = {op, fields[19:10], imm};
			if (op >= 6'h20)
				readData1 = 32'(randBits(8)); // Small base address
		end
		modelExecute(instruction, readData1, readData2);
		instrValid = 1'b1;
		upCredits--;
		sentCount++;
	endtask

	task automatic checkOutputs();
		logic [31:0] value;
		logic write;
		string name;
		if (instrCredit) begin
			upCredits++;
			creditPulses++;
		end
		if (resultValid) begin
			beatCount++;
			downCredits--;
			if (downCredits < 0) begin
				$display("Result beat %0d arrived without an output credit", beatCount);
				protocolErrors++;
			end
			if (expName.size() == 0) begin
				$display("Result beat %0d arrived with no instruction outstanding", beatCount);
				protocolErrors++;
			end else begin
				value = expValue.pop_front();
				write = expWrite.pop_front();
				name = expName.pop_front();
				if (resultWrite !== write) begin
					$display("FAIL %s resultWrite: expected %0b, actual %0b", name, write,
						resultWrite);
					valueErrors++;
				end
				if (write && result !== value) begin
					$display("FAIL %s result: expected %h, actual %h", name, value, result);
					valueErrors++;
				end
			end
		end
	endtask

	task automatic driveInputs();
		instrValid = 1'b0;
		resultCredit = 1'b0;
		if (sentCount < NumInstr && upCredits > 0 && randBits(2) != 0)
			sendInstruction();
		if (downCredits < `EXEC_CREDIT_MAX && randBits(2) == 0) begin
			resultCredit = 1'b1; // Sparse credit pulses
			downCredits++;
		end
		memWaitRequest = (randBits(1) != 0);
		memReadData = memRead ? busMem[memAddress[7:2]] : 32'h0;
		if (memWrite && !memWaitRequest) begin // Completes at the next rising edge
			for (int b = 0; b < 4; b++) begin
				if (memByteEnable[b])
					busMem[memAddress[7:2]][b*8 +: 8] = memWriteData[b*8 +: 8];
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		instrValid = 1'b0;
		instruction = 32'h0;
		readData1 = 32'h0;
		readData2 = 32'h0;
		resultCredit = 1'b0;
		memWaitRequest = 1'b0;
		memReadData = 32'h0;
		lfsrState = 16'd37;
		sentCount = 0;
		beatCount = 0;
		upCredits = `EXEC_QUEUE_DEPTH;
		downCredits = 0;
		creditPulses = 0;
		drainCycles = 0;
		valueErrors = 0;
		protocolErrors = 0;
		memoryErrors = 0;
		modelHi = 32'h0;
		modelLo = 32'h0;
		for (int i = 0; i < 64; i++) begin
			busMem[6'(i)] = randBits(32);
			modelMem[6'(i)] = busMem[6'(i)];
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (drainCycles < 10) begin
			@(negedge clk);
			checkOutputs();
			driveInputs();
			if (beatCount >= NumInstr)
				drainCycles++; // Catch stray beats and credits
		end
		if (creditPulses != NumInstr) begin
			$display("instrCredit pulsed %0d times for %0d instructions", creditPulses, NumInstr);
			protocolErrors++;
		end
		if (expName.size() != 0) begin
			$display("%0d expected results never arrived", expName.size());
			protocolErrors++;
		end
		for (int i = 0; i < 64; i++) begin
			if (busMem[6'(i)] !== modelMem[6'(i)]) begin
				$display("FAIL STORE word %0d: expected %h, actual %h", i, modelMem[6'(i)],
					busMem[6'(i)]);
				memoryErrors++;
			end
		end
		$display("Errors: value %0d, protocol %0d, memory %0d", valueErrors, protocolErrors,
			memoryErrors);
		if (valueErrors + protocolErrors + memoryErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		repeat (NumInstr * 60) @(posedge clk);
		$display("Watchdog expired with %0d of %0d results received", beatCount, NumInstr);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/mipsIsaPkg.sv
source/execPkg.sv
source/issueQueue.sv
source/mipsAlu.sv
source/hiLoUnit.sv
source/loadStoreUnit.sv
source/mipsExecCore.sv
verif/mipsExec_checker.sv
verif/mipsExecTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module mipsExecTb -o simExec
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simExec > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -qx "Test OK" sim.log; then
	exit 0
fi
exit 1
